/* bench/lsu_patterns.txt */
# hex columns: store funct3 addr store_data exp_load_data exp_err
# funct3: 0 lb/sb, 1 lh/sh, 2 lw/sw, 4 lbu, 5 lhu
1 2 00000000 11223344 00000000 0
1 2 00000004 a5b6c7d8 00000000 0
0 2 00000000 00000000 11223344 0
0 2 00000004 00000000 a5b6c7d8 0
1 2 00000010 00000000 00000000 0
1 0 00000010 000000aa 00000000 0
1 0 00000011 000000bb 00000000 0
1 0 00000012 000000cc 00000000 0
1 0 00000013 000000dd 00000000 0
0 2 00000010 00000000 ddccbbaa 0
1 2 00000014 ffffffff 00000000 0
1 1 00000014 00001234 00000000 0
1 1 00000016 00005678 00000000 0
0 2 00000014 00000000 56781234 0
1 2 00000020 92c37f81 00000000 0
0 0 00000020 00000000 ffffff81 0
0 0 00000021 00000000 0000007f 0
0 0 00000022 00000000 ffffffc3 0
0 0 00000023 00000000 ffffff92 0
0 4 00000020 00000000 00000081 0
0 4 00000023 00000000 00000092 0
0 1 00000020 00000000 00007f81 0
0 1 00000022 00000000 ffff92c3 0
0 5 00000022 00000000 000092c3 0
0 1 00000021 00000000 00000000 1
0 2 00000022 00000000 00000000 1
0 5 00000023 00000000 00000000 1
1 1 00000005 0000ffff 00000000 1
1 2 00000006 deadbeef 00000000 1
0 2 00000004 00000000 a5b6c7d8 0
1 2 000003fc 0badc0de 00000000 0
0 2 000003fc 00000000 0badc0de 0
1 2 00000400 cafef00d 00000000 1
0 2 00000400 00000000 00000000 1
0 0 00000ffd 00000000 00000000 1
0 2 00000000 00000000 11223344 0

/* bench/lsu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_tb;

    localparam int MEM_WORDS = 256;

    logic               clk;
    logic               rst;
    logic               in_valid;
    lsu_pkg::lsu_req_t  in_req;
    logic               in_ready;
    logic               out_valid;
    lsu_pkg::lsu_resp_t out_resp;
    logic               out_ready;

    lsu_pkg::lsu_req_t  reqs[$];
    lsu_pkg::xlen_t     exp_data[$];
    logic               exp_err[$];
    lsu_pkg::lsu_resp_t got[$];

    logic [15:0]        lfsr;
    logic               held;
    lsu_pkg::lsu_resp_t held_resp;
    logic               loaded;
    bit                 file_ok;
    int                 error_count;
    int                 check_count;

    tb_clock #(.PERIOD(4)) i_tb_clock (.clk(clk));

    lsu_top #(
        .MEM_WORDS (MEM_WORDS)
    ) i_lsu_top (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_resp  (out_resp),
        .out_ready (out_ready)
    );

    // taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] next_lfsr(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic read_patterns(output bit ok);
        int                fd;
        int                n;
        logic [8*128-1:0]  line;
        logic [31:0]       f_store;
        logic [31:0]       f_funct3;
        logic [31:0]       f_addr;
        logic [31:0]       f_data;
        logic [31:0]       f_exp;
        logic [31:0]       f_err;
        lsu_pkg::lsu_req_t req;
        fd = $fopen("bench/lsu_patterns.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                n = $sscanf(line, "%h %h %h %h %h %h",
                            f_store, f_funct3, f_addr, f_data, f_exp, f_err);
                // comment and blank lines fail to parse
                if (n == 6) begin
                    req.store = f_store[0];
                    req.width = lsu_pkg::mem_width_t'(f_funct3[2:0]);
                    req.addr  = f_addr;
                    req.data  = f_data;
                    reqs.push_back(req);
                    exp_data.push_back(f_exp);
                    exp_err.push_back(f_err[0]);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_pattern(input int idx);
        lsu_pkg::lsu_resp_t resp;
        int                 errs_before;
        errs_before = error_count;
        @(posedge clk);
        #1;
        in_req   = reqs[idx];
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        while (got.size() == 0) begin
            @(posedge clk);
        end
        resp = got.pop_front();
        check_count += 2;
        if (resp.data !== exp_data[idx]) begin
            $display("MISMATCH at %0t ns: out_resp.data expected %08h actual %08h",
                     $time, exp_data[idx], resp.data);
            error_count++;
        end
        if (resp.err !== exp_err[idx]) begin
            $display("MISMATCH at %0t ns: out_resp.err expected %0b actual %0b",
                     $time, exp_err[idx], resp.err);
            error_count++;
        end
        $display("test %0d: %s funct3 %0d addr %08h %s", idx,
                 reqs[idx].store ? "store" : "load", int'(reqs[idx].width),
                 reqs[idx].addr, (error_count == errs_before) ? "ok" : "FAILED");
    endtask

    // random back-pressure, one lfsr bit per cycle
    always @(posedge clk) begin
        #1;
        lfsr      = next_lfsr(lfsr);
        out_ready = lfsr[0];
    end

    // collect responses and watch that a held response stays put
    always @(negedge clk) begin
        if (!rst) begin
            if (held && !out_valid) begin
                $display("out_valid dropped at %0t ns before the response was taken", $time);
                error_count++;
            end else if (held && (out_resp !== held_resp)) begin
                $display("MISMATCH at %0t ns: out_resp expected %09h actual %09h",
                         $time, held_resp, out_resp);
                error_count++;
            end
            if (out_valid && out_ready) begin
                got.push_back(out_resp);
            end
            held      = out_valid && !out_ready;
            held_resp = out_resp;
        end
    end

    initial begin
        wait (loaded);
        repeat (reqs.size() * 40 + 64) @(posedge clk);
        $display("run timed out after %0d cycles", reqs.size() * 40 + 64);
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_req      = '0;
        out_ready   = 1'b0;
        lfsr        = 16'd93;
        held        = 1'b0;
        held_resp   = '0;
        loaded      = 1'b0;
        error_count = 0;
        check_count = 0;
        read_patterns(file_ok);
        if (!file_ok) begin
            $display("could not open bench/lsu_patterns.txt");
            $display("Checks failed");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (16) @(posedge clk);
            #1;
            rst = 1'b0;
            @(negedge clk);
            check_count += 2;
            if (out_valid !== 1'b0) begin
                $display("MISMATCH at %0t ns: out_valid expected 0 actual %0b",
                         $time, out_valid);
                error_count++;
            end
            if (in_ready !== 1'b1) begin
                $display("MISMATCH at %0t ns: in_ready expected 1 actual %0b",
                         $time, in_ready);
                error_count++;
            end
            for (int i = 0; i < reqs.size(); i++) begin
                apply_pattern(i);
            end
            // nothing more may come out once all requests are answered
            repeat (8) @(posedge clk);
            check_count++;
            if (got.size() != 0) begin
                $display("%0d responses arrived without a request", got.size());
                error_count++;
            end
            $display("%0d tests, %0d checks, %0d errors",
                     reqs.size(), check_count, error_count);
            if (error_count == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

/* lsu_top.f */
rtl/lsu_pkg.sv
rtl/store_align.sv
rtl/load_align.sv
rtl/lsu.sv
rtl/axi_lite_dmem.sv
rtl/lsu_top.sv
bench/tb_clock.sv
bench/lsu_tb.sv

/* rtl/axi_lite_dmem.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_lite_dmem #(
    parameter int MEM_WORDS = 256
) (
    input  logic             clk,
    input  logic             rst,

    input  lsu_pkg::axi_ax_t ar,
    input  logic             arvalid,
    output logic             arready,

    output lsu_pkg::axi_r_t  r,
    output logic             rvalid,
    input  logic             rready,

    input  lsu_pkg::axi_ax_t aw,
    input  logic             awvalid,
    output logic             awready,

    input  lsu_pkg::axi_w_t  w,
    input  logic             wvalid,
    output logic             wready,

    output lsu_pkg::axi_b_t  b,
    output logic             bvalid,
    input  logic             bready
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    lsu_pkg::xlen_t mem [MEM_WORDS];

    logic             wr_ready;
    logic             rd_fire;
    logic             wr_fire;
    logic             rd_in_range;
    logic             wr_in_range;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    // aw and w are accepted in the same cycle
    assign awready = wr_ready;
    assign wready  = wr_ready;

    assign rd_fire = arvalid && arready;
    assign wr_fire = awvalid && awready && wvalid && wready;

    assign rd_in_range = (ar.addr[31:2] < MEM_WORDS);
    assign wr_in_range = (aw.addr[31:2] < MEM_WORDS);
    assign rd_idx      = ar.addr[IDX_W+1:2];
    assign wr_idx      = aw.addr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            // one cycle pulse, not while a read is still pending
            arready <= arvalid && !arready && !rvalid;
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end

            wr_ready <= awvalid && wvalid && !wr_ready && !bvalid;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            r.data <= rd_in_range ? mem[rd_idx] : '0;
            r.resp <= rd_in_range ? lsu_pkg::OKAY : lsu_pkg::SLVERR;
        end
        if (wr_fire) begin
            b.resp <= wr_in_range ? lsu_pkg::OKAY : lsu_pkg::SLVERR;
            if (wr_in_range) begin
                for (int i = 0; i < 4; i++) begin
                    if (w.strb[i]) begin
                        mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/load_align.sv */
`timescale 1ns/1ns
`default_nettype none

module load_align (
    input  lsu_pkg::mem_width_t width,
    input  lsu_pkg::addr_t      addr,
    input  lsu_pkg::xlen_t      word,
    output lsu_pkg::xlen_t      data,
    output logic                misaligned
);

    logic [1:0]     offset;
    lsu_pkg::xlen_t shifted;

    assign offset  = addr[1:0];
    assign shifted = word >> {offset, 3'b000};

    always_comb begin
        case (width)
            lsu_pkg::MEM_B: begin
                data = {{24{shifted[7]}}, shifted[7:0]};
            end
            lsu_pkg::MEM_H: begin
                data = {{16{shifted[15]}}, shifted[15:0]};
            end
            lsu_pkg::MEM_BU: begin
                data = {24'b0, shifted[7:0]};
            end
            lsu_pkg::MEM_HU: begin
                data = {16'b0, shifted[15:0]};
            end
            default: begin
                data = shifted;
            end
        endcase
    end

    // same rule as on the store side
    assign misaligned = (((width == lsu_pkg::MEM_H) || (width == lsu_pkg::MEM_HU)) &&
                         offset[0]) ||
                        ((width == lsu_pkg::MEM_W) && (offset != 2'b00));

endmodule

`default_nettype wire

/* rtl/lsu.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu (
    input  logic               clk,
    input  logic               rst,

    input  logic               in_valid,
    input  lsu_pkg::lsu_req_t  in_req,
    output logic               in_ready,

    output logic               out_valid,
    output lsu_pkg::lsu_resp_t out_resp,
    input  logic               out_ready,

    output lsu_pkg::axi_ax_t   ar,
    output logic               arvalid,
    input  logic               arready,

    input  lsu_pkg::axi_r_t    r,
    input  logic               rvalid,
    output logic               rready,

    output lsu_pkg::axi_ax_t   aw,
    output logic               awvalid,
    input  logic               awready,

    output lsu_pkg::axi_w_t    w,
    output logic               wvalid,
    input  logic               wready,

    input  lsu_pkg::axi_b_t    b,
    input  logic               bvalid,
    output logic               bready
);

    lsu_pkg::lsu_state_t state;
    lsu_pkg::lsu_req_t   req_q;
    lsu_pkg::lsu_req_t   cur_req;
    lsu_pkg::lsu_resp_t  resp_q;

    logic           aw_done;
    logic           w_done;
    logic           in_fire;
    logic           aw_fire;
    logic           w_fire;
    logic           misaligned;
    logic           st_misaligned;
    logic           ld_misaligned;
    lsu_pkg::xlen_t st_lane;
    lsu_pkg::strb_t st_strb;
    lsu_pkg::xlen_t ld_data;

    // alignment is checked on the incoming request while idle
    assign cur_req = (state == lsu_pkg::ST_IDLE) ? in_req : req_q;

    store_align i_store_align (
        .width      (cur_req.width),
        .addr       (cur_req.addr),
        .data       (cur_req.data),
        .lane_data  (st_lane),
        .strb       (st_strb),
        .misaligned (st_misaligned)
    );

    load_align i_load_align (
        .width      (cur_req.width),
        .addr       (cur_req.addr),
        .word       (r.data),
        .data       (ld_data),
        .misaligned (ld_misaligned)
    );

    assign misaligned = cur_req.store ? st_misaligned : ld_misaligned;

    assign in_ready  = (state == lsu_pkg::ST_IDLE);
    assign in_fire   = in_valid && in_ready;
    assign out_valid = (state == lsu_pkg::ST_RESP);
    assign out_resp  = resp_q;

    // word aligned bus address
    assign ar.addr = {req_q.addr[31:2], 2'b00};
    assign aw.addr = {req_q.addr[31:2], 2'b00};
    assign w.data  = st_lane;
    assign w.strb  = st_strb;

    assign arvalid = (state == lsu_pkg::ST_RADDR);
    assign rready  = (state == lsu_pkg::ST_RDATA);
    assign awvalid = (state == lsu_pkg::ST_WRITE) && !aw_done;
    assign wvalid  = (state == lsu_pkg::ST_WRITE) && !w_done;
    assign bready  = (state == lsu_pkg::ST_WRESP);

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= lsu_pkg::ST_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                lsu_pkg::ST_IDLE: begin
                    if (in_fire) begin
                        if (misaligned) begin
                            state <= lsu_pkg::ST_RESP;
                        end else if (in_req.store) begin
                            state <= lsu_pkg::ST_WRITE;
                        end else begin
                            state <= lsu_pkg::ST_RADDR;
                        end
                    end
                end
                lsu_pkg::ST_RADDR: begin
                    if (arready) begin
                        state <= lsu_pkg::ST_RDATA;
                    end
                end
                lsu_pkg::ST_RDATA: begin
                    if (rvalid) begin
                        state <= lsu_pkg::ST_RESP;
                    end
                end
                lsu_pkg::ST_WRITE: begin
                    if (aw_fire) begin
                        aw_done <= 1'b1;
                    end
                    if (w_fire) begin
                        w_done <= 1'b1;
                    end
                    // aw and w may complete in different cycles
                    if ((aw_done || aw_fire) && (w_done || w_fire)) begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= lsu_pkg::ST_WRESP;
                    end
                end
                lsu_pkg::ST_WRESP: begin
                    if (bvalid) begin
                        state <= lsu_pkg::ST_RESP;
                    end
                end
                lsu_pkg::ST_RESP: begin
                    if (out_ready) begin
                        state <= lsu_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= lsu_pkg::ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            req_q       <= in_req;
            resp_q.data <= '0;
            resp_q.err  <= misaligned;
        end
        if (rready && rvalid) begin
            resp_q.data <= (r.resp == lsu_pkg::OKAY) ? ld_data : '0;
            resp_q.err  <= (r.resp != lsu_pkg::OKAY);
        end
        if (bready && bvalid) begin
            resp_q.data <= '0;
            resp_q.err  <= (b.resp != lsu_pkg::OKAY);
        end
    end

endmodule

`default_nettype wire

/* rtl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0] strb_t;

    // funct3 encodings of the load/store width
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_width_t;

    typedef logic [1:0] axi_resp_t;
    localparam axi_resp_t OKAY   = 2'b00;
    localparam axi_resp_t SLVERR = 2'b10;

    typedef struct packed {
        logic       store;
        mem_width_t width;
        addr_t      addr;
        xlen_t      data;
    } lsu_req_t;

    typedef struct packed {
        xlen_t data;
        logic  err;
    } lsu_resp_t;

    // shared by AR and AW
    typedef struct packed {
        addr_t addr;
    } axi_ax_t;

    typedef struct packed {
        xlen_t data;
        strb_t strb;
    } axi_w_t;

    typedef struct packed {
        xlen_t     data;
        axi_resp_t resp;
    } axi_r_t;

    typedef struct packed {
        axi_resp_t resp;
    } axi_b_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RADDR,
        ST_RDATA,
        ST_WRITE,
        ST_WRESP,
        ST_RESP
    } lsu_state_t;

endpackage

`default_nettype wire

/* rtl/lsu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  lsu_pkg::lsu_req_t  in_req,
    output logic               in_ready,
    output logic               out_valid,
    output lsu_pkg::lsu_resp_t out_resp,
    input  logic               out_ready
);

    lsu_pkg::axi_ax_t ar;
    lsu_pkg::axi_ax_t aw;
    lsu_pkg::axi_w_t  w;
    lsu_pkg::axi_r_t  r;
    lsu_pkg::axi_b_t  b;

    logic arvalid;
    logic arready;
    logic rvalid;
    logic rready;
    logic awvalid;
    logic awready;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;

    lsu i_lsu (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_resp  (out_resp),
        .out_ready (out_ready),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .b         (b),
        .bvalid    (bvalid),
        .bready    (bready)
    );

    axi_lite_dmem #(
        .MEM_WORDS (MEM_WORDS)
    ) i_dmem (
        .clk     (clk),
        .rst     (rst),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

`default_nettype wire

/* rtl/store_align.sv */
`timescale 1ns/1ns
`default_nettype none

module store_align (
    input  lsu_pkg::mem_width_t width,
    input  lsu_pkg::addr_t      addr,
    input  lsu_pkg::xlen_t      data,
    output lsu_pkg::xlen_t      lane_data,
    output lsu_pkg::strb_t      strb,
    output logic                misaligned
);

    logic [1:0] offset;

    assign offset = addr[1:0];

    // byte offset times eight
    assign lane_data = data << {offset, 3'b000};

    always_comb begin
        case (width)
            lsu_pkg::MEM_B: begin
                strb = 4'b0001 << offset;
            end
            lsu_pkg::MEM_H: begin
                strb = 4'b0011 << offset;
            end
            lsu_pkg::MEM_W: begin
                strb = 4'b1111;
            end
            default: begin
                strb = 4'b0000;
            end
        endcase
    end

    assign misaligned = ((width == lsu_pkg::MEM_H) && offset[0]) ||
                        ((width == lsu_pkg::MEM_W) && (offset != 2'b00));

endmodule

`default_nettype wire
